//--- source/kcpu_config.svh
/* kcpu configuration macros */

`ifndef KCPU_CONFIG_SVH
`define KCPU_CONFIG_SVH

// datapath widths
`define KCPU_PC_W 16
`define KCPU_OP_W 8

// program counter value after reset
`define KCPU_RESET_PC 16'h0000

// width of the interrupt vector code
`define KCPU_VEC_W 3

// intvec stays at this code outside of vector fetch
`define KCPU_VEC_NONE 3'd0

// non-maskable interrupt entry
`define KCPU_VEC_NMI 3'd1

// maskable interrupt entry gated by cc bit I
`define KCPU_VEC_IRQ 3'd2

`endif

//--- source/kcpu_isa_pkg.sv
/* kcpu instruction set definitions */

`default_nettype none

`include "kcpu_config.svh"

package kcpu_isa_pkg;

    // opcodes handled by the control section
    // anything not listed here runs as a NOP
    typedef enum logic [`KCPU_OP_W-1:0] {
        OP_NOP       = 8'h12,
        // short conditional branches with the condition in the low nibble
        OP_BCC_BASE  = 8'h20,
        // long conditional branches use the same condition encoding
        OP_LBCC_BASE = 8'h30,
        // bit 0 picks B over A
        OP_LDA       = 8'h40,
        OP_LDB       = 8'h41,
        // bits 3:1 pick D, X, Y, U or S
        OP_LD16      = 8'h50,
        OP_LEAX      = 8'h60,
        OP_LEAY      = 8'h61,
        OP_LEAU      = 8'h62,
        OP_LEAS      = 8'h63,
        // bit 0 means pull and bit 1 selects the U stack
        OP_PSHS      = 8'h70,
        OP_PULS      = 8'h71,
        OP_PSHU      = 8'h72,
        OP_PULU      = 8'h73,
        OP_JMP       = 8'h7E
    } kcpu_op_e;

    // branch conditions in 6809 order
    typedef enum logic [3:0] {
        COND_BRA, COND_BRN, COND_BHI, COND_BLS,
        COND_BCC, COND_BCS, COND_BNE, COND_BEQ,
        COND_BVC, COND_BVS, COND_BPL, COND_BMI,
        COND_BGE, COND_BLT, COND_BGT, COND_BLE
    } kcpu_cond_e;

    // bit positions inside the condition code register
    localparam int unsigned CC_C = 0;
    localparam int unsigned CC_V = 1;
    localparam int unsigned CC_Z = 2;
    localparam int unsigned CC_N = 3;
    localparam int unsigned CC_I = 4;

endpackage

`default_nettype wire

//--- source/kcpu_seq_pkg.sv
/* kcpu sequencer types */

`default_nettype none

package kcpu_seq_pkg;

    // instruction phases of the microcode sequencer
    typedef enum logic [2:0] {
        ST_DECODE,
        ST_EXEC,
        ST_STACK,
        ST_VECTOR,
        ST_NEXT
    } kcpu_state_e;

    // bit index inside a push/pull mask
    // entries from STK_X upwards are 16-bit registers
    typedef enum logic [2:0] {
        STK_CC,
        STK_A,
        STK_B,
        STK_DP,
        STK_X,
        STK_Y,
        STK_US,
        STK_PC
    } kcpu_stkreg_e;

endpackage

`default_nettype wire

//--- source/kcpu_branch.sv
/* kcpu branch condition evaluator */

`timescale 1ns/100ps
`default_nettype none

module kcpu_branch (
    input  logic [3:0] op,
    input  logic [7:0] cc,
    output logic       branch
);

    logic c;
    logic v;
    logic z;
    logic n;
    logic lt;

    assign c = cc[kcpu_isa_pkg::CC_C];
    assign v = cc[kcpu_isa_pkg::CC_V];
    assign z = cc[kcpu_isa_pkg::CC_Z];
    assign n = cc[kcpu_isa_pkg::CC_N];

    // signed less-than after a compare
    assign lt = n ^ v;

    always_comb begin
        case (kcpu_isa_pkg::kcpu_cond_e'(op))
            kcpu_isa_pkg::COND_BRA: branch = 1'b1;
            kcpu_isa_pkg::COND_BRN: branch = 1'b0;
            // unsigned compares
            kcpu_isa_pkg::COND_BHI: branch = ~(c | z);
            kcpu_isa_pkg::COND_BLS: branch = c | z;
            kcpu_isa_pkg::COND_BCC: branch = ~c;
            kcpu_isa_pkg::COND_BCS: branch = c;
            kcpu_isa_pkg::COND_BNE: branch = ~z;
            kcpu_isa_pkg::COND_BEQ: branch = z;
            kcpu_isa_pkg::COND_BVC: branch = ~v;
            kcpu_isa_pkg::COND_BVS: branch = v;
            kcpu_isa_pkg::COND_BPL: branch = ~n;
            kcpu_isa_pkg::COND_BMI: branch = n;
            // signed compares
            kcpu_isa_pkg::COND_BGE: branch = ~lt;
            kcpu_isa_pkg::COND_BLT: branch = lt;
            kcpu_isa_pkg::COND_BGT: branch = ~(z | lt);
            kcpu_isa_pkg::COND_BLE: branch = z | lt;
            default:                branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/kcpu_pshpul.sv
/* kcpu push/pull sequencer */

`timescale 1ns/100ps
`default_nettype none

module kcpu_pshpul (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       mem_busy,
    input  logic [1:0] op,
    input  logic [7:0] postdata,
    input  logic       psh_go,
    input  logic       pul_go,
    input  logic       psh_all,
    output logic       busy,
    output logic       wrq,
    output logic       pshdec,
    output logic       pul_en,
    output logic       hi_lon,
    output logic       us_sel,
    output logic [7:0] psh_sel
);

    logic [7:0] pend;
    logic [7:0] pend_nx;
    logic       second;
    logic       second_nx;
    logic       pull_q;
    logic       go;
    logic       active;
    logic       advance;
    logic       is16;
    logic       done_bit;
    kcpu_seq_pkg::kcpu_stkreg_e cur;

    assign go      = psh_go | pul_go;
    assign active  = |pend;
    assign advance = active & ~mem_busy;

    // push takes the highest pending bit, pull the lowest
    always_comb begin
        cur = kcpu_seq_pkg::STK_CC;
        for (int i = 0; i < 8; i++) begin
            if (!pull_q && pend[i]) cur = kcpu_seq_pkg::kcpu_stkreg_e'(i[2:0]);
        end
        for (int i = 7; i >= 0; i--) begin
            if (pull_q && pend[i]) cur = kcpu_seq_pkg::kcpu_stkreg_e'(i[2:0]);
        end
    end

    assign is16     = cur >= kcpu_seq_pkg::STK_X;
    assign done_bit = ~is16 | second;

    always_comb begin
        pend_nx   = pend;
        second_nx = second;
        if (go) begin
            pend_nx   = psh_all ? 8'hFF : postdata;
            second_nx = 1'b0;
        end else if (advance) begin
            if (done_bit) pend_nx = pend & ~psh_sel;
            second_nx = is16 & ~second;
        end
    end

    // high when a byte transfer is scheduled for the next cycle
    assign busy = |pend_nx;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend   <= 8'd0;
            second <= 1'b0;
            pull_q <= 1'b0;
            us_sel <= 1'b0;
        end else if (cen) begin
            pend   <= pend_nx;
            second <= second_nx;
            if (go) begin
                pull_q <= ~psh_all & op[0];
                us_sel <= ~psh_all & op[1];
            end
        end
    end

    assign psh_sel = active ? (8'b1 << cur) : 8'd0;
    // push sends the low byte first, pull reads the high byte first
    assign hi_lon  = is16 & (pull_q ? ~second : second);
    assign wrq     = advance & ~pull_q;
    assign pshdec  = advance & ~pull_q;
    assign pul_en  = advance & pull_q;

endmodule

`default_nettype wire

//--- source/kcpu_ucode.sv
/* kcpu microcode sequencer */

`timescale 1ns/100ps
`default_nettype none

`include "kcpu_config.svh"

module kcpu_ucode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic [`KCPU_OP_W-1:0]  op,
    input  logic [7:0]             cc,
    input  logic                   mem_busy,
    input  logic                   irq_n,
    input  logic                   nmi_n,
    input  logic                   branch,
    input  logic                   stk_busy,
    output logic                   ni,
    output logic                   opd,
    output logic                   short_br,
    output logic                   long_br,
    output logic                   pc_load,
    output logic                   up_ld8,
    output logic                   up_ld16,
    output logic                   up_lea,
    output logic                   psh_go,
    output logic                   pul_go,
    output logic                   psh_all,
    output logic                   set_i,
    output logic [`KCPU_VEC_W-1:0] intvec
);

    localparam logic [`KCPU_OP_W-1:0] LD8_OP  = kcpu_isa_pkg::OP_LDA;
    localparam logic [`KCPU_OP_W-1:0] LD16_OP = kcpu_isa_pkg::OP_LD16;
    localparam logic [`KCPU_OP_W-1:0] LEA_OP  = kcpu_isa_pkg::OP_LEAX;
    localparam logic [`KCPU_OP_W-1:0] BCC_OP  = kcpu_isa_pkg::OP_BCC_BASE;
    localparam logic [`KCPU_OP_W-1:0] LBCC_OP = kcpu_isa_pkg::OP_LBCC_BASE;
    localparam logic [`KCPU_OP_W-1:0] STK_OP  = kcpu_isa_pkg::OP_PSHS;

    kcpu_seq_pkg::kcpu_state_e state;
    kcpu_seq_pkg::kcpu_state_e state_nx;

    logic [2:0]             nmi_s;
    logic [1:0]             irq_s;
    logic                   nmi_lat;
    logic                   nmi_take;
    logic                   irq_take;
    logic [`KCPU_VEC_W-1:0] int_code;
    logic                   is_ld8;
    logic                   is_ld16;
    logic                   is_lea;
    logic                   is_bcc;
    logic                   is_lbcc;
    logic                   is_jmp;
    logic                   is_stk;

    // opcode classes
    // op stays stable until the next ni
    assign is_ld8  = op[7:1] == LD8_OP[7:1];
    assign is_ld16 = (op[7:4] == LD16_OP[7:4]) && !op[0] && (op[3:1] <= 3'd4);
    assign is_lea  = op[7:2] == LEA_OP[7:2];
    assign is_bcc  = op[7:4] == BCC_OP[7:4];
    assign is_lbcc = op[7:4] == LBCC_OP[7:4];
    assign is_jmp  = op == kcpu_isa_pkg::OP_JMP;
    assign is_stk  = op[7:2] == STK_OP[7:2];

    // interrupts are only looked at between instructions
    assign nmi_take = (state == kcpu_seq_pkg::ST_NEXT) && nmi_lat;
    assign irq_take = (state == kcpu_seq_pkg::ST_NEXT) && !nmi_lat && !irq_s[1]
                      && !cc[kcpu_isa_pkg::CC_I];

    always_ff @(posedge clk) begin
        if (rst) begin
            nmi_s   <= 3'b111;
            irq_s   <= 2'b11;
            nmi_lat <= 1'b0;
        end else if (cen) begin
            nmi_s <= {nmi_s[1:0], nmi_n};
            irq_s <= {irq_s[0], irq_n};
            // a new falling edge wins over the clear
            if (nmi_s[2] && !nmi_s[1]) nmi_lat <= 1'b1;
            else if (nmi_take) nmi_lat <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= kcpu_seq_pkg::ST_NEXT;
            int_code <= `KCPU_VEC_NONE;
        end else if (cen) begin
            state <= state_nx;
            if (nmi_take) int_code <= `KCPU_VEC_NMI;
            else if (irq_take) int_code <= `KCPU_VEC_IRQ;
            else if (state == kcpu_seq_pkg::ST_VECTOR) int_code <= `KCPU_VEC_NONE;
        end
    end

    always_comb begin
        state_nx = state;
        ni       = 1'b0;
        opd      = 1'b0;
        short_br = 1'b0;
        long_br  = 1'b0;
        pc_load  = 1'b0;
        up_ld8   = 1'b0;
        up_ld16  = 1'b0;
        up_lea   = 1'b0;
        psh_go   = 1'b0;
        pul_go   = 1'b0;
        psh_all  = 1'b0;
        set_i    = 1'b0;
        intvec   = `KCPU_VEC_NONE;
        case (state)
            kcpu_seq_pkg::ST_NEXT: begin
                if (nmi_take || irq_take) begin
                    // full register dump on the S stack
                    psh_go   = 1'b1;
                    psh_all  = 1'b1;
                    state_nx = kcpu_seq_pkg::ST_STACK;
                end else begin
                    ni       = 1'b1;
                    state_nx = kcpu_seq_pkg::ST_DECODE;
                end
            end
            kcpu_seq_pkg::ST_DECODE: begin
                if (is_stk) begin
                    opd      = 1'b1;
                    psh_go   = ~op[0];
                    pul_go   = op[0];
                    state_nx = stk_busy ? kcpu_seq_pkg::ST_STACK : kcpu_seq_pkg::ST_NEXT;
                end else if (is_ld8 || is_ld16 || is_lea || is_bcc || is_lbcc || is_jmp) begin
                    opd      = 1'b1;
                    state_nx = kcpu_seq_pkg::ST_EXEC;
                end else begin
                    state_nx = kcpu_seq_pkg::ST_NEXT;
                end
            end
            kcpu_seq_pkg::ST_EXEC: begin
                if (!mem_busy) begin
                    up_ld8   = is_ld8;
                    up_ld16  = is_ld16;
                    up_lea   = is_lea;
                    short_br = is_bcc & branch;
                    long_br  = is_lbcc & branch;
                    pc_load  = is_jmp;
                    state_nx = kcpu_seq_pkg::ST_NEXT;
                end
            end
            kcpu_seq_pkg::ST_STACK: begin
                if (!mem_busy && !stk_busy) begin
                    state_nx = (int_code != `KCPU_VEC_NONE) ? kcpu_seq_pkg::ST_VECTOR
                                                            : kcpu_seq_pkg::ST_NEXT;
                end
            end
            kcpu_seq_pkg::ST_VECTOR: begin
                intvec   = int_code;
                set_i    = 1'b1;
                pc_load  = 1'b1;
                state_nx = kcpu_seq_pkg::ST_NEXT;
            end
            default: state_nx = kcpu_seq_pkg::ST_NEXT;
        endcase
    end

endmodule

`default_nettype wire

//--- source/kcpu_ctrl.sv
/* kcpu control section top */

`timescale 1ns/100ps
`default_nettype none

`include "kcpu_config.svh"

module kcpu_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic [`KCPU_OP_W-1:0]  op,
    input  logic [7:0]             postdata,
    input  logic [7:0]             cc,
    input  logic [`KCPU_PC_W-1:0]  data,
    input  logic                   mem_busy,
    input  logic                   irq_n,
    input  logic                   nmi_n,
    output logic                   ni,
    output logic                   opd,
    output logic                   wrq,
    output logic                   pshdec,
    output logic                   pul_en,
    output logic                   hi_lon,
    output logic                   us_sel,
    output logic [7:0]             psh_sel,
    output logic                   set_i,
    output logic [`KCPU_VEC_W-1:0] intvec,
    output logic                   up_a,
    output logic                   up_b,
    output logic                   up_d,
    output logic                   up_x,
    output logic                   up_y,
    output logic                   up_u,
    output logic                   up_s,
    output logic [`KCPU_PC_W-1:0]  pc
);

    localparam logic [`KCPU_OP_W-1:0] LEAX_OP = kcpu_isa_pkg::OP_LEAX;
    localparam logic [`KCPU_OP_W-1:0] LEAY_OP = kcpu_isa_pkg::OP_LEAY;
    localparam logic [`KCPU_OP_W-1:0] LEAU_OP = kcpu_isa_pkg::OP_LEAU;
    localparam logic [`KCPU_OP_W-1:0] LEAS_OP = kcpu_isa_pkg::OP_LEAS;

    logic       branch;
    logic       short_br;
    logic       long_br;
    logic       pc_load;
    logic       up_ld8;
    logic       up_ld16;
    logic       up_lea;
    logic       psh_go;
    logic       pul_go;
    logic       psh_all;
    logic       stk_busy;
    logic [2:0] ld16_sel;
    logic [1:0] lea_sel;

    // register load decode
    assign ld16_sel = op[3:1];
    assign lea_sel  = op[1:0];

    assign up_a = up_ld8 & ~op[0];
    assign up_b = up_ld8 &  op[0];
    assign up_d = up_ld16 && (ld16_sel == 3'd0);
    assign up_x = (up_ld16 && (ld16_sel == 3'd1)) || (up_lea && (lea_sel == LEAX_OP[1:0]));
    assign up_y = (up_ld16 && (ld16_sel == 3'd2)) || (up_lea && (lea_sel == LEAY_OP[1:0]));
    assign up_u = (up_ld16 && (ld16_sel == 3'd3)) || (up_lea && (lea_sel == LEAU_OP[1:0]));
    assign up_s = (up_ld16 && (ld16_sel == 3'd4)) || (up_lea && (lea_sel == LEAS_OP[1:0]));

    // fetch increments win over branches, branches over plain loads
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `KCPU_RESET_PC;
        end else if (cen) begin
            if (ni || opd) pc <= pc + `KCPU_PC_W'(1);
            else if (short_br && branch) pc <= pc + {{(`KCPU_PC_W-8){data[7]}}, data[7:0]};
            else if (long_br && branch) pc <= pc + data;
            else if (pc_load) pc <= data;
        end
    end

    kcpu_ucode u_ucode (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( cen      ),
        .op       ( op       ),
        .cc       ( cc       ),
        .mem_busy ( mem_busy ),
        .irq_n    ( irq_n    ),
        .nmi_n    ( nmi_n    ),
        .branch   ( branch   ),
        .stk_busy ( stk_busy ),
        .ni       ( ni       ),
        .opd      ( opd      ),
        .short_br ( short_br ),
        .long_br  ( long_br  ),
        .pc_load  ( pc_load  ),
        .up_ld8   ( up_ld8   ),
        .up_ld16  ( up_ld16  ),
        .up_lea   ( up_lea   ),
        .psh_go   ( psh_go   ),
        .pul_go   ( pul_go   ),
        .psh_all  ( psh_all  ),
        .set_i    ( set_i    ),
        .intvec   ( intvec   )
    );

    kcpu_branch u_branch (
        .op     ( op[3:0] ),
        .cc     ( cc      ),
        .branch ( branch  )
    );

    kcpu_pshpul u_pshpul (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( cen      ),
        .mem_busy ( mem_busy ),
        .op       ( op[1:0]  ),
        .postdata ( postdata ),
        .psh_go   ( psh_go   ),
        .pul_go   ( pul_go   ),
        .psh_all  ( psh_all  ),
        .busy     ( stk_busy ),
        .wrq      ( wrq      ),
        .pshdec   ( pshdec   ),
        .pul_en   ( pul_en   ),
        .hi_lon   ( hi_lon   ),
        .us_sel   ( us_sel   ),
        .psh_sel  ( psh_sel  )
    );

endmodule

`default_nettype wire

//--- tests/kcpu_ctrl_assert.sv
/* kcpu control strobe assertions */

`timescale 1ns/100ps
`default_nettype none

module kcpu_ctrl_assert (
    input logic clk,
    input logic rst,
    input logic mem_busy,
    input logic wrq,
    input logic pshdec,
    input logic pul_en,
    input logic set_i,
    input logic up_a,
    input logic up_b,
    input logic up_d,
    input logic up_x,
    input logic up_y,
    input logic up_u,
    input logic up_s
);

    logic [6:0] up;

    assign up = {up_a, up_b, up_d, up_x, up_y, up_u, up_s};

    // first reset cycle still shows the power-up state
    a_reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !(|up) && !wrq && !pshdec && !pul_en && !set_i)
        else $error("strobe active during reset");

    a_up_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(up))
        else $error("more than one register load strobe");

    a_dir: assert property (@(posedge clk) disable iff (rst) !(wrq && pul_en))
        else $error("push and pull active together");

    a_busy_wrq: assert property (@(posedge clk) disable iff (rst) mem_busy |-> !wrq)
        else $error("write request during memory stall");

endmodule

bind kcpu_ctrl kcpu_ctrl_assert u_assert (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .mem_busy ( mem_busy ),
    .wrq      ( wrq      ),
    .pshdec   ( pshdec   ),
    .pul_en   ( pul_en   ),
    .set_i    ( set_i    ),
    .up_a     ( up_a     ),
    .up_b     ( up_b     ),
    .up_d     ( up_d     ),
    .up_x     ( up_x     ),
    .up_y     ( up_y     ),
    .up_u     ( up_u     ),
    .up_s     ( up_s     )
);

`default_nettype wire

//--- tests/kcpu_ctrl_tb.sv
/* kcpu control section testbench */

`timescale 1ns/100ps
`default_nettype none

`include "kcpu_config.svh"

module kcpu_ctrl_tb;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  op;
    logic [7:0]  postdata;
    logic [7:0]  cc;
    logic [15:0] data;
    logic        mem_busy;
    logic        irq_n;
    logic        nmi_n;
    logic        ni;
    logic        opd;
    logic        wrq;
    logic        pshdec;
    logic        pul_en;
    logic        hi_lon;
    logic        us_sel;
    logic [7:0]  psh_sel;
    logic        set_i;
    logic [2:0]  intvec;
    logic        up_a;
    logic        up_b;
    logic        up_d;
    logic        up_x;
    logic        up_y;
    logic        up_u;
    logic        up_s;
    logic [15:0] pc;

    int          errors;
    int          timeouts;
    logic [15:0] exp_pc;
    logic        irq_drive;
    int          ncyc;
    int          opd_idx;
    int          up_cnt;
    int          up_idx;
    logic [6:0]  up_val;
    logic [12:0] stk_q[$];
    logic [12:0] exp_q[$];

    kcpu_ctrl UUT (.*);

    always #5 clk = ~clk;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // 6809 condition table
    function automatic logic cond_holds(input logic [3:0] c, input logic [7:0] f);
        logic cf;
        logic vf;
        logic zf;
        logic nf;
        cf = f[kcpu_isa_pkg::CC_C];
        vf = f[kcpu_isa_pkg::CC_V];
        zf = f[kcpu_isa_pkg::CC_Z];
        nf = f[kcpu_isa_pkg::CC_N];
        case (c)
            4'd0:    return 1'b1;
            4'd1:    return 1'b0;
            4'd2:    return !cf && !zf;
            4'd3:    return cf || zf;
            4'd4:    return !cf;
            4'd5:    return cf;
            4'd6:    return !zf;
            4'd7:    return zf;
            4'd8:    return !vf;
            4'd9:    return vf;
            4'd10:   return !nf;
            4'd11:   return nf;
            4'd12:   return nf == vf;
            4'd13:   return nf != vf;
            4'd14:   return !zf && (nf == vf);
            default: return zf || (nf != vf);
        endcase
    endfunction

    // strobe order a, b, d, x, y, u, s from the msb
    function automatic logic [6:0] expect_up(input logic [7:0] o);
        case (o)
            8'h40:   return 7'b1000000;
            8'h41:   return 7'b0100000;
            8'h50:   return 7'b0010000;
            8'h52, 8'h60: return 7'b0001000;
            8'h54, 8'h61: return 7'b0000100;
            8'h56, 8'h62: return 7'b0000010;
            8'h58, 8'h63: return 7'b0000001;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic logic [12:0] stk_entry(input logic us, input logic pull, input logic hi,
                                              input logic [7:0] sel);
        return {us, pull, ~pull, ~pull, hi, sel};
    endfunction

    task automatic build_stack(input logic [7:0] mask, input logic pull, input logic us);
        int i;
        exp_q.delete();
        for (int k = 0; k < 8; k++) begin
            i = pull ? k : 7 - k;
            if (mask[i]) begin
                if (i >= int'(kcpu_seq_pkg::STK_X)) begin
                    // push sends low byte first, pull reads high byte first
                    exp_q.push_back(stk_entry(us, pull, pull, 8'd1 << i));
                    exp_q.push_back(stk_entry(us, pull, ~pull, 8'd1 << i));
                end else begin
                    exp_q.push_back(stk_entry(us, pull, 1'b0, 8'd1 << i));
                end
            end
        end
    endtask

    task automatic compare_stack(input string what);
        check({what, " stack length"}, stk_q.size(), exp_q.size());
        for (int k = 0; k < stk_q.size() && k < exp_q.size(); k++)
            check({what, " stack entry"}, stk_q[k], exp_q[k]);
    endtask

    // issue one instruction at the ni cycle and follow it up to the next ni
    task automatic run_instr(input logic [7:0] opc, input logic [15:0] dat,
                             input logic [7:0] pdat, input logic [7:0] ccv, input logic stall);
        logic [6:0] upv;
        logic       done;
        @(posedge clk);
        op       <= opc;
        data     <= dat;
        postdata <= pdat;
        cc       <= ccv;
        irq_n    <= irq_drive;
        nmi_n    <= 1'b1;
        mem_busy <= stall ? 1'($urandom_range(0, 1)) : 1'b0;
        ncyc     = 0;
        opd_idx  = -1;
        up_cnt   = 0;
        up_idx   = -1;
        up_val   = 7'd0;
        stk_q.delete();
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            ncyc++;
            upv = {up_a, up_b, up_d, up_x, up_y, up_u, up_s};
            if (mem_busy)
                check("strobes during stall", {upv, wrq, pshdec, pul_en}, 0);
            if (upv != 7'd0) begin
                up_cnt++;
                up_val = upv;
                up_idx = ncyc;
            end
            if (opd)
                opd_idx = ncyc;
            if (wrq || pul_en)
                stk_q.push_back({us_sel, pul_en, pshdec, wrq, hi_lon, psh_sel});
            if (ni) begin
                done = 1'b1;
            end else if (ncyc > 100) begin
                timeouts++;
                $display("timeout: opcode %0h did not reach the next instruction", opc);
                done = 1'b1;
            end else begin
                @(posedge clk);
                mem_busy <= stall ? 1'($urandom_range(0, 1)) : 1'b0;
            end
        end
    endtask

    task automatic basic_timing();
        run_instr(kcpu_isa_pkg::OP_NOP, 16'd0, 8'd0, 8'h10, 1'b0);
        exp_pc = exp_pc + 16'd1;
        check("nop cycles", ncyc, 2);
        check("nop pc", pc, exp_pc);
        run_instr(kcpu_isa_pkg::OP_LDA, 16'h1234, 8'd0, 8'h10, 1'b0);
        exp_pc = exp_pc + 16'd2;
        check("operand cycles", ncyc, 3);
        check("operand pc", pc, exp_pc);
    endtask

    task automatic load_test(input logic stall);
        logic [7:0] ops [11] = '{8'h40, 8'h41, 8'h50, 8'h52, 8'h54, 8'h56, 8'h58,
                                 8'h60, 8'h61, 8'h62, 8'h63};
        foreach (ops[k]) begin
            run_instr(ops[k], 16'($urandom), 8'd0, 8'($urandom), stall);
            exp_pc = exp_pc + 16'd2;
            check("load strobe count", up_cnt, 1);
            check("load strobe", up_val, expect_up(ops[k]));
            check("load pc", pc, exp_pc);
            if (!stall) begin
                check("load strobe cycle", up_idx, opd_idx + 1);
                check("load cycles", ncyc, 3);
            end
        end
    endtask

    task automatic branch_test(input logic stall);
        logic [15:0] dat;
        logic [7:0]  ccv;
        logic [15:0] base;
        for (int c = 0; c < 16; c++) begin
            for (int lng = 0; lng < 2; lng++) begin
                dat  = 16'($urandom);
                ccv  = 8'($urandom);
                base = exp_pc + 16'd2;
                run_instr((lng != 0 ? 8'h30 : 8'h20) | 8'(c), dat, 8'd0, ccv, stall);
                if (!cond_holds(4'(c), ccv))
                    exp_pc = base;
                else if (lng != 0)
                    exp_pc = base + dat;
                else
                    exp_pc = base + {{8{dat[7]}}, dat[7:0]};
                check("branch pc", pc, exp_pc);
            end
        end
        dat = 16'($urandom);
        run_instr(kcpu_isa_pkg::OP_JMP, dat, 8'd0, 8'h10, stall);
        exp_pc = dat;
        check("jmp pc", pc, exp_pc);
    endtask

    task automatic stack_test(input logic stall);
        logic [7:0] mask;
        for (int o = 8'h70; o <= 8'h73; o++) begin
            for (int r = 0; r < 6; r++) begin
                mask = (r == 0) ? 8'h00 : (r == 1) ? 8'hFF : 8'($urandom);
                run_instr(8'(o), 16'd0, mask, 8'h10, stall);
                build_stack(mask, o[0], o[1]);
                compare_stack("psh/pul");
                exp_pc = exp_pc + 16'd2;
                check("stack pc", pc, exp_pc);
                if (!stall)
                    check("stack cycles", ncyc, 2 + exp_q.size());
            end
        end
    endtask

    // an LDA stalled in execute gives the request lines time to settle
    task automatic interrupt_test(input logic use_irq, input logic use_nmi, input logic masked,
                                  input logic [2:0] code);
        logic [15:0] vec;
        int          n;
        logic        took;
        logic        waiting;
        vec = 16'($urandom);
        build_stack(8'hFF, 1'b0, 1'b0);
        stk_q.delete();
        @(posedge clk);
        op        <= kcpu_isa_pkg::OP_LDA;
        data      <= vec;
        cc        <= masked ? 8'h10 : 8'h00;
        mem_busy  <= 1'b1;
        irq_drive = ~use_irq;
        irq_n     <= ~use_irq;
        nmi_n     <= ~use_nmi;
        repeat (6) @(posedge clk);
        mem_busy <= 1'b0;
        n = 0;
        took = 1'b0;
        waiting = 1'b1;
        while (waiting) begin
            @(negedge clk);
            n++;
            if (wrq)
                stk_q.push_back({us_sel, pul_en, pshdec, wrq, hi_lon, psh_sel});
            if (set_i) begin
                took = 1'b1;
                waiting = 1'b0;
                check("intvec", intvec, code);
            end else if (ni) begin
                waiting = 1'b0;
            end else if (n > 100) begin
                timeouts++;
                $display("timeout: interrupt entry did not finish");
                waiting = 1'b0;
            end else begin
                @(posedge clk);
            end
        end
        check("interrupt taken", took, !masked);
        if (masked) begin
            check("masked push count", stk_q.size(), 0);
            exp_pc = exp_pc + 16'd2;
            check("masked pc", pc, exp_pc);
            run_instr(kcpu_isa_pkg::OP_NOP, 16'd0, 8'd0, 8'h10, 1'b0);
            exp_pc = exp_pc + 16'd1;
            check("masked nop cycles", ncyc, 2);
            irq_drive = 1'b1;
            run_instr(kcpu_isa_pkg::OP_NOP, 16'd0, 8'd0, 8'h10, 1'b0);
            exp_pc = exp_pc + 16'd1;
            check("masked nop pc", pc, exp_pc);
        end else if (took) begin
            compare_stack("interrupt");
            @(posedge clk);
            cc        <= 8'h10;
            irq_drive = 1'b1;
            irq_n     <= 1'b1;
            nmi_n     <= 1'b1;
            @(negedge clk);
            exp_pc = vec;
            check("ni after vector", ni, 1);
            check("vector pc", pc, exp_pc);
        end
    endtask

    initial begin
        int n;
        void'($urandom(81));
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        op = kcpu_isa_pkg::OP_NOP;
        postdata = 8'd0;
        cc = 8'h10;
        data = 16'd0;
        mem_busy = 1'b0;
        irq_n = 1'b1;
        nmi_n = 1'b1;
        irq_drive = 1'b1;
        errors = 0;
        timeouts = 0;
        exp_pc = `KCPU_RESET_PC;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("strobes in reset", {up_a, up_b, up_d, up_x, up_y, up_u, up_s, wrq, pul_en}, 0);
        @(posedge clk);
        rst <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ni && n < 20);
        if (!ni) begin
            timeouts++;
            $display("timeout: no instruction fetch after reset");
        end
        check("reset pc", pc, exp_pc);
        check("reset strobes", {up_a, up_b, up_d, up_x, up_y, up_u, up_s, wrq, pshdec,
                                pul_en, intvec}, 0);
        basic_timing();
        load_test(1'b0);
        branch_test(1'b0);
        stack_test(1'b0);
        load_test(1'b1);
        branch_test(1'b1);
        stack_test(1'b1);
        interrupt_test(1'b1, 1'b0, 1'b1, 3'd0);
        interrupt_test(1'b1, 1'b0, 1'b0, `KCPU_VEC_IRQ);
        interrupt_test(1'b0, 1'b1, 1'b0, `KCPU_VEC_NMI);
        interrupt_test(1'b1, 1'b1, 1'b0, `KCPU_VEC_NMI);
        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- kcpu_ctrl.f
+incdir+source
source/kcpu_isa_pkg.sv
source/kcpu_seq_pkg.sv
source/kcpu_branch.sv
source/kcpu_pshpul.sv
source/kcpu_ucode.sv
source/kcpu_ctrl.sv
tests/kcpu_ctrl_assert.sv
tests/kcpu_ctrl_tb.sv

//--- run_sim.sh
#!/bin/bash
# compile and run the kcpu control testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module kcpu_ctrl_tb -f kcpu_ctrl.f -o kcpu_sim > sim.log 2>&1 \
    && ./obj_dir/kcpu_sim >> sim.log 2>&1 \
    || echo "TESTS FAILED" >> sim.log

cat sim.log

grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
